// File: hdl/mipsDefs.svh
`ifndef MIPS_DEFS_SVH
`define MIPS_DEFS_SVH

// First instruction fetch address after reset
`define RESET_VECTOR 32'hBFC00000

// Jumping here stops the CPU
`define HALT_ADDR 32'h00000000

// Register numbers with a fixed role
// $v0, exported for observation
`define REG_V0 5'd2
// $ra, link register for JAL
`define REG_RA 5'd31

`endif

// File: hdl/mipsIsaPkg.sv
`default_nettype none

package mipsIsaPkg;

    // Data word and register index
    typedef logic [31:0] word_t;
    typedef logic [4:0] regAddr_t;

    // Primary opcodes of the supported subset
    typedef enum logic [5:0] {
        OP_SPECIAL = 6'h00,
        OP_J       = 6'h02,
        OP_JAL     = 6'h03,
        OP_BEQ     = 6'h04,
        OP_BNE     = 6'h05,
        OP_ADDIU   = 6'h09,
        OP_SLTIU   = 6'h0B,
        OP_ANDI    = 6'h0C,
        OP_ORI     = 6'h0D,
        OP_LUI     = 6'h0F,
        OP_LW      = 6'h23,
        OP_SW      = 6'h2B
    } opcode_t;

    // Function field for SPECIAL (R-type) instructions
    typedef enum logic [5:0] {
        F_SLL  = 6'h00,
        F_JR   = 6'h08,
        F_ADDU = 6'h21,
        F_SUBU = 6'h23,
        F_AND  = 6'h24,
        F_OR   = 6'h25,
        F_XOR  = 6'h26,
        F_SLTU = 6'h2B
    } funct_t;

endpackage

`default_nettype wire

// File: hdl/mipsCtrlPkg.sv
`default_nettype none

package mipsCtrlPkg;

    // Multicycle sequencer states
    typedef enum logic [1:0] {FETCH, EXEC, MEM, HALT} cpuState_t;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLTU,
        ALU_SLL,
        ALU_LUI
    } aluOp_t;

    // Source of the next PC
    typedef enum logic [1:0] {PC_SEQ, PC_BRANCH, PC_JUMP, PC_REG} pcSel_t;

    // Source of the register writeback value
    typedef enum logic [1:0] {WB_ALU, WB_MEM, WB_LINK} wbSel_t;

endpackage

`default_nettype wire

// File: hdl/regFile.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefs.svh"

module regFile (
    input  logic                 clk,
    input  logic                 rstN,
    input  mipsIsaPkg::regAddr_t rs,
    input  mipsIsaPkg::regAddr_t rt,
    output mipsIsaPkg::word_t    rdata1,
    output mipsIsaPkg::word_t    rdata2,
    input  logic                 wen,
    input  mipsIsaPkg::regAddr_t waddr,
    input  mipsIsaPkg::word_t    wdata,
    output mipsIsaPkg::word_t    v0
);
    import mipsIsaPkg::*;

    // Register zero has no storage
    word_t regs [1:31];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && waddr != '0) begin
            regs[waddr] <= wdata;
        end
    end

    // Combinational reads, $zero always reads as zero
    assign rdata1 = (rs == '0) ? '0 : regs[rs];
    assign rdata2 = (rt == '0) ? '0 : regs[rt];

    assign v0 = regs[`REG_V0];

endmodule

`default_nettype wire

// File: hdl/aluUnit.sv
`timescale 1ns/1ps
`default_nettype none

module aluUnit (
    input  mipsIsaPkg::word_t   a,
    input  mipsIsaPkg::word_t   b,
    input  logic [4:0]          shamt,
    input  mipsCtrlPkg::aluOp_t op,
    output mipsIsaPkg::word_t   result,
    output logic                zero
);
    import mipsCtrlPkg::*;

    always_comb begin
        unique case (op)
            ALU_ADD: begin
                result = a + b;
            end
            ALU_SUB: begin
                result = a - b;
            end
            ALU_AND: begin
                result = a & b;
            end
            ALU_OR: begin
                result = a | b;
            end
            ALU_XOR: begin
                result = a ^ b;
            end
            // Unsigned compare, result is 0 or 1
            ALU_SLTU: begin
                result = {31'b0, (a < b)};
            end
            // Logical left shift of the rt operand
            ALU_SLL: begin
                result = b << shamt;
            end
            // Immediate into the upper half
            ALU_LUI: begin
                result = {b[15:0], 16'b0};
            end
            default: begin
                result = '0;
            end
        endcase
    end

    // Used with ALU_SUB for branch comparison
    assign zero = (result == '0);

endmodule

`default_nettype wire

// File: hdl/controlDecoder.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefs.svh"

module controlDecoder (
    input  mipsIsaPkg::word_t    instr,
    output mipsCtrlPkg::aluOp_t  aluOp,
    output logic                 aluSrcImm,
    output logic                 regWrite,
    output logic                 isLoad,
    output logic                 isStore,
    output logic                 branchNe,
    output mipsIsaPkg::word_t    immExt,
    output mipsIsaPkg::regAddr_t destReg,
    output mipsCtrlPkg::pcSel_t  pcSel,
    output mipsCtrlPkg::wbSel_t  wbSel
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    opcode_t  opcode;
    funct_t   funct;
    regAddr_t rt;
    regAddr_t rd;
    logic     zeroExt;

    assign opcode = opcode_t'(instr[31:26]);
    assign funct  = funct_t'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];

    // Logical immediates are zero extended
    assign zeroExt = (opcode == OP_ANDI) || (opcode == OP_ORI);
    assign immExt  = zeroExt ? {16'b0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};

    always_comb begin
        // Defaults decode to a no-op
        aluOp     = ALU_ADD;
        aluSrcImm = 1'b0;
        regWrite  = 1'b0;
        isLoad    = 1'b0;
        isStore   = 1'b0;
        branchNe  = 1'b0;
        destReg   = rt;
        pcSel     = PC_SEQ;
        wbSel     = WB_ALU;

        case (opcode)
            OP_SPECIAL: begin
                destReg  = rd;
                regWrite = 1'b1;
                case (funct)
                    F_ADDU: aluOp = ALU_ADD;
                    F_SUBU: aluOp = ALU_SUB;
                    F_AND:  aluOp = ALU_AND;
                    F_OR:   aluOp = ALU_OR;
                    F_XOR:  aluOp = ALU_XOR;
                    F_SLTU: aluOp = ALU_SLTU;
                    F_SLL:  aluOp = ALU_SLL;
                    F_JR: begin
                        regWrite = 1'b0;
                        pcSel    = PC_REG;
                    end
                    default: regWrite = 1'b0;
                endcase
            end
            OP_ADDIU, OP_ANDI, OP_ORI, OP_SLTIU, OP_LUI: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                case (opcode)
                    OP_ANDI:  aluOp = ALU_AND;
                    OP_ORI:   aluOp = ALU_OR;
                    OP_SLTIU: aluOp = ALU_SLTU;
                    OP_LUI:   aluOp = ALU_LUI;
                    default:  aluOp = ALU_ADD;
                endcase
            end
            // Address is base plus offset
            OP_LW: begin
                aluSrcImm = 1'b1;
                regWrite  = 1'b1;
                isLoad    = 1'b1;
                wbSel     = WB_MEM;
            end
            OP_SW: begin
                aluSrcImm = 1'b1;
                isStore   = 1'b1;
            end
            OP_BEQ, OP_BNE: begin
                aluOp    = ALU_SUB;
                pcSel    = PC_BRANCH;
                branchNe = (opcode == OP_BNE);
            end
            OP_J: begin
                pcSel = PC_JUMP;
            end
            OP_JAL: begin
                pcSel    = PC_JUMP;
                regWrite = 1'b1;
                destReg  = `REG_RA;
                wbSel    = WB_LINK;
            end
            default: begin
            end
        endcase
    end

endmodule

`default_nettype wire

// File: hdl/mipsCpuBus.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefs.svh"

module mipsCpuBus (
    input  logic              clk,
    input  logic              rstN,
    output logic              active,
    output mipsIsaPkg::word_t register_v0,
    input  logic              waitrequest,
    input  mipsIsaPkg::word_t readdata,
    output mipsIsaPkg::word_t address,
    output logic              write,
    output logic              read,
    output mipsIsaPkg::word_t writedata,
    output logic [3:0]        byteenable
);
    import mipsIsaPkg::*;
    import mipsCtrlPkg::*;

    cpuState_t state;
    word_t     pc;
    word_t     instr;
    word_t     memAddr;
    word_t     storeData;

    regAddr_t  rs;
    regAddr_t  rt;
    regAddr_t  destReg;
    word_t     rsVal;
    word_t     rtVal;
    word_t     immExt;
    word_t     aluB;
    word_t     aluResult;
    logic      zero;
    aluOp_t    aluOp;
    logic      aluSrcImm;
    logic      regWrite;
    logic      isLoad;
    logic      isStore;
    logic      branchNe;
    pcSel_t    pcSel;
    wbSel_t    wbSel;

    word_t     pcPlus4;
    word_t     branchTarget;
    word_t     jumpTarget;
    word_t     nextPc;
    word_t     wbData;
    logic      regWen;
    logic      isMem;
    logic      branchTaken;

    assign rs    = instr[25:21];
    assign rt    = instr[20:16];
    assign isMem = isLoad || isStore;

    controlDecoder decoder0 (
        .instr(instr), .aluOp(aluOp), .aluSrcImm(aluSrcImm), .regWrite(regWrite),
        .isLoad(isLoad), .isStore(isStore), .branchNe(branchNe), .immExt(immExt),
        .destReg(destReg), .pcSel(pcSel), .wbSel(wbSel)
    );

    regFile regs0 (
        .clk(clk), .rstN(rstN), .rs(rs), .rt(rt), .rdata1(rsVal), .rdata2(rtVal),
        .wen(regWen), .waddr(destReg), .wdata(wbData), .v0(register_v0)
    );

    assign aluB = aluSrcImm ? immExt : rtVal;

    aluUnit alu0 (
        .a(rsVal), .b(aluB), .shamt(instr[10:6]), .op(aluOp),
        .result(aluResult), .zero(zero)
    );

    // No delay slot, targets are relative to the next instruction
    assign pcPlus4      = pc + 32'd4;
    assign branchTarget = pcPlus4 + {immExt[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], instr[25:0], 2'b00};
    assign branchTaken  = zero ^ branchNe;

    always_comb begin
        unique case (pcSel)
            PC_BRANCH: nextPc = branchTaken ? branchTarget : pcPlus4;
            PC_JUMP:   nextPc = jumpTarget;
            PC_REG:    nextPc = rsVal;
            default:   nextPc = pcPlus4;
        endcase
    end

    always_comb begin
        unique case (wbSel)
            WB_MEM:  wbData = readdata;
            WB_LINK: wbData = pcPlus4;
            default: wbData = aluResult;
        endcase
    end

    // Writeback in EXEC, or when the load completes in MEM
    assign regWen = regWrite &&
                    ((state == EXEC && !isMem) || (state == MEM && isLoad && !waitrequest));

    always_ff @(posedge clk) begin
        if (!rstN) begin
            state  <= FETCH;
            pc     <= `RESET_VECTOR;
            instr  <= '0;
            active <= 1'b0;
        end else begin
            case (state)
                FETCH: begin
                    active <= 1'b1;
                    if (active && !waitrequest) begin
                        instr <= readdata;
                        state <= EXEC;
                    end
                end
                EXEC: begin
                    if (isMem) begin
                        state <= MEM;
                    end else begin
                        pc <= nextPc;
                        if (nextPc == `HALT_ADDR) begin
                            state  <= HALT;
                            active <= 1'b0;
                        end else begin
                            state <= FETCH;
                        end
                    end
                end
                MEM: begin
                    if (!waitrequest) begin
                        pc    <= pcPlus4;
                        state <= FETCH;
                    end
                end
                default: begin
                    state <= HALT;
                end
            endcase
        end
    end

    // Effective address and store data held through the MEM access
    always_ff @(posedge clk) begin
        if (state == EXEC && isMem) begin
            memAddr   <= aluResult;
            storeData <= rtVal;
        end
    end

    assign read       = (state == FETCH && active) || (state == MEM && isLoad);
    assign write      = (state == MEM) && isStore;
    assign address    = (state == MEM) ? memAddr : pc;
    assign writedata  = storeData;
    assign byteenable = 4'b1111;

endmodule

`default_nettype wire

// File: tb/busMemModel.sv
`timescale 1ns/1ps
`default_nettype none

module busMemModel (
    input  logic              clk,
    input  logic              rstN,
    input  logic              stallEn,
    input  mipsIsaPkg::word_t address,
    input  logic              read,
    input  logic              write,
    input  mipsIsaPkg::word_t writedata,
    output mipsIsaPkg::word_t readdata,
    output logic              waitrequest
);
    import mipsIsaPkg::*;

    // Sparse storage indexed by word address
    word_t mem [word_t];
    word_t logAddr [$];
    word_t logData [$];
    logic  inAccess;
    int    stallLeft;

    // Unwritten words return a pattern built from the full address
    function automatic word_t peek(word_t addr);
        if (mem.exists(addr >> 2)) begin
            return mem[addr >> 2];
        end
        return {addr[15:0], addr[31:16]} ^ 32'hA5A5A5A5;
    endfunction

    task automatic loadWord(input word_t addr, input word_t data);
        mem[addr >> 2] = data;
    endtask

    task automatic clearAll();
        mem.delete();
        logAddr.delete();
        logData.delete();
    endtask

    initial begin
        readdata    = '0;
        waitrequest = 1'b0;
        inAccess    = 1'b0;
        stallLeft   = 0;
    end

    // An access completes on the rising edge with waitrequest low
    always @(posedge clk) begin
        if (!rstN) begin
            inAccess <= 1'b0;
        end else if ((read || write) && !waitrequest) begin
            inAccess <= 1'b0;
            if (write) begin
                mem[address >> 2] = writedata;
                logAddr.push_back(address);
                logData.push_back(writedata);
            end
        end
    end

    // Responses change on the falling edge
    always @(negedge clk) begin
        if (rstN && (read || write)) begin
            // New request draws its stall length once
            if (!inAccess) begin
                inAccess <= 1'b1;
                stallLeft = stallEn ? int'($urandom % 4) : 0;
            end
            waitrequest <= (stallLeft != 0);
            if (stallLeft != 0) begin
                stallLeft--;
            end
            readdata <= read ? peek(address) : '0;
        end else begin
            waitrequest <= 1'b0;
        end
    end

endmodule

`default_nettype wire

// File: tb/mipsCpuBusAssert.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefs.svh"

module mipsCpuBusAssert (
    input logic                   clk,
    input logic                   rstN,
    input logic                   active,
    input logic                   read,
    input logic                   write,
    input logic                   waitrequest,
    input mipsIsaPkg::word_t      address,
    input mipsIsaPkg::word_t      writedata,
    input mipsCtrlPkg::cpuState_t state
);
    import mipsCtrlPkg::*;

    // Failed properties so far, watched by the testbench
    int failCount = 0;

    strobeExclusive: assert property (@(posedge clk) disable iff (!rstN)
        !(read && write))
        else begin
            failCount++;
            $error("read and write high in the same cycle");
        end

    // A stalled request keeps strobe, address and store data
    holdWhileStalled: assert property (@(posedge clk) disable iff (!rstN)
        ((read || write) && waitrequest) |=>
            (read == $past(read)) && (write == $past(write)) && $stable(address) &&
            (!write || $stable(writedata)))
        else begin
            failCount++;
            $error("bus request changed while waitrequest was high");
        end

    quietWhenInactive: assert property (@(posedge clk) disable iff (!rstN)
        !active |-> !(read || write))
        else begin
            failCount++;
            $error("bus strobe high while active is low");
        end

    haltParked: assert property (@(posedge clk) disable iff (!rstN)
        (state == HALT) |-> !active && (address == `HALT_ADDR))
        else begin
            failCount++;
            $error("halted CPU is active or left the halt address");
        end

endmodule

bind mipsCpuBus mipsCpuBusAssert assert0 (
    .clk(clk),
    .rstN(rstN),
    .active(active),
    .read(read),
    .write(write),
    .waitrequest(waitrequest),
    .address(address),
    .writedata(writedata),
    .state(state)
);

`default_nettype wire

// File: tb/mipsCpuBusTb.sv
`timescale 1ns/1ps
`default_nettype none

`include "mipsDefs.svh"

module mipsCpuBusTb;
    import mipsIsaPkg::*;

    localparam int CLK_PERIOD = 20;
    // Summing loop at N = 20 is the longest program
    localparam int MAX_INSTR = 80;
    localparam int STALL_MAX = 3;
    // Fetch, execute and memory cycles with both accesses fully stalled
    localparam int CYCLES_PER_INSTR = 3 + 2 * STALL_MAX;
    localparam int RUN_COUNT = 5;
    localparam int RUN_EXTRA = 40;
    localparam longint TIMEOUT_NS =
        longint'(CLK_PERIOD) * RUN_COUNT * (MAX_INSTR * CYCLES_PER_INSTR + RUN_EXTRA);
    localparam word_t DATA_BASE = 32'h0000_1000;

    logic       clk;
    logic       rstN;
    logic       stallEn;
    logic       active;
    word_t      registerV0;
    logic       waitrequest;
    word_t      readdata;
    word_t      address;
    logic       write;
    logic       read;
    word_t      writedata;
    logic [3:0] byteenable;

    // Program image, initial data and expected write log of the next run
    word_t      prog [$];
    word_t      dataAddr [$];
    word_t      dataVal [$];
    word_t      expAddr [$];
    word_t      expData [$];
    word_t      opA;
    word_t      opB;
    logic [4:0] shamt;
    word_t      imms [5];

    mipsCpuBus dut0 (
        .clk(clk), .rstN(rstN), .active(active), .register_v0(registerV0),
        .waitrequest(waitrequest), .readdata(readdata), .address(address),
        .write(write), .read(read), .writedata(writedata), .byteenable(byteenable)
    );

    busMemModel mem0 (
        .clk(clk), .rstN(rstN), .stallEn(stallEn), .address(address), .read(read),
        .write(write), .writedata(writedata),
        .readdata(readdata), .waitrequest(waitrequest)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    function automatic word_t rType(funct_t fn, regAddr_t rs, regAddr_t rt, regAddr_t rd,
                                    logic [4:0] sa);
        return {OP_SPECIAL, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t iType(opcode_t op, regAddr_t rs, regAddr_t rt, logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic word_t jType(opcode_t op, word_t target);
        return {op, target[27:2]};
    endfunction

    // Expected value from the instruction semantics
    function automatic word_t expectedResult(string kind, word_t a, word_t b);
        word_t immS;
        word_t immZ;
        word_t total;
        immS = {{16{b[15]}}, b[15:0]};
        immZ = {16'h0, b[15:0]};
        case (kind)
            "addu":  return a + b;
            "subu":  return a - b;
            "and":   return a & b;
            "or":    return a | b;
            "xor":   return a ^ b;
            "sltu":  return (a < b) ? 32'd1 : 32'd0;
            "sll":   return a << b[4:0];
            "addiu": return a + immS;
            "andi":  return a & immZ;
            "ori":   return a | immZ;
            "sltiu": return (a < immS) ? 32'd1 : 32'd0;
            "lui":   return {b[15:0], 16'h0};
            // Sum of 1 to a, then the subroutine adds b
            "sumcall": begin
                total = immS;
                for (int i = 1; i <= a; i++) begin
                    total += i;
                end
                return total;
            end
            default: return '0;
        endcase
    endfunction

    task automatic abortRun();
        $display("Simulation finished: FAIL");
        $fatal(1, "Stopped at the first error");
    endtask

    task automatic checkValue(input string name, input word_t actual, input word_t expected);
        if (actual !== expected) begin
            $display("Fail %s: got %h, expected %h", name, actual, expected);
            abortRun();
        end
    endtask

    // Reset, load memory, run until the CPU halts, then watch the idle bus
    task automatic runProgram(input logic stalls);
        @(negedge clk);
        rstN    = 1'b0;
        stallEn = stalls;
        mem0.clearAll();
        foreach (prog[i]) begin
            mem0.loadWord(`RESET_VECTOR + 4 * i, prog[i]);
        end
        foreach (dataAddr[i]) begin
            mem0.loadWord(dataAddr[i], dataVal[i]);
        end
        repeat (3) @(negedge clk);
        rstN = 1'b1;
        while (!(read || write)) begin
            @(negedge clk);
        end
        checkValue("read", read, 1);
        checkValue("address", address, `RESET_VECTOR);
        checkValue("byteenable", byteenable, 4'hF);
        checkValue("active", active, 1);
        while (active) begin
            @(negedge clk);
        end
        repeat (20) begin
            @(negedge clk);
            checkValue("read", read, 0);
            checkValue("write", write, 0);
            checkValue("active", active, 0);
        end
    endtask

    task automatic checkWrites(input word_t v0Exp);
        checkValue("write count", mem0.logAddr.size(), expAddr.size());
        foreach (expAddr[i]) begin
            checkValue("write address", mem0.logAddr[i], expAddr[i]);
            checkValue("writedata", mem0.logData[i], expData[i]);
        end
        checkValue("register_v0", registerV0, v0Exp);
    endtask

    // Same program again with random stalls
    task automatic rerunWithStalls(input word_t v0Exp);
        runProgram(1'b1);
        checkWrites(v0Exp);
    endtask

    task automatic buildAluProgram();
        funct_t fns [7] = '{F_ADDU, F_SUBU, F_AND, F_OR, F_XOR, F_SLTU, F_SLL};
        string  kinds [7] = '{"addu", "subu", "and", "or", "xor", "sltu", "sll"};
        prog = {iType(OP_ADDIU, 0, 8, DATA_BASE[15:0]), iType(OP_LW, 8, 9, 16'h0),
                iType(OP_LW, 8, 10, 16'h4)};
        dataAddr = {DATA_BASE, DATA_BASE + 32'h4};
        dataVal  = {opA, opB};
        expAddr.delete();
        expData.delete();
        foreach (fns[i]) begin
            // SLL shifts rt, so the first operand sits in rt
            if (fns[i] == F_SLL) begin
                prog.push_back(rType(F_SLL, 0, 9, 11, shamt));
                expData.push_back(expectedResult(kinds[i], opA, word_t'(shamt)));
            end else begin
                prog.push_back(rType(fns[i], 9, 10, 11, 5'd0));
                expData.push_back(expectedResult(kinds[i], opA, opB));
            end
            prog.push_back(iType(OP_SW, 8, 11, 16'h100 + 16'(4 * i)));
            expAddr.push_back(DATA_BASE + 32'h100 + 4 * i);
        end
        prog.push_back(rType(F_JR, 0, 0, 0, 5'd0));
    endtask

    task automatic buildImmProgram();
        opcode_t  ops [5] = '{OP_ADDIU, OP_ANDI, OP_ORI, OP_SLTIU, OP_LUI};
        string    kinds [5] = '{"addiu", "andi", "ori", "sltiu", "lui"};
        regAddr_t src;
        prog = {iType(OP_ADDIU, 0, 8, DATA_BASE[15:0]), iType(OP_LW, 8, 9, 16'h0)};
        dataAddr.delete();
        dataVal.delete();
        dataAddr.push_back(DATA_BASE);
        dataVal.push_back(opA);
        expAddr.delete();
        expData.delete();
        foreach (ops[i]) begin
            // LUI has no source register
            src = (ops[i] == OP_LUI) ? 5'd0 : 5'd9;
            prog.push_back(iType(ops[i], src, `REG_V0, imms[i][15:0]));
            prog.push_back(iType(OP_SW, 8, `REG_V0, 16'h100 + 16'(4 * i)));
            expAddr.push_back(DATA_BASE + 32'h100 + 4 * i);
            expData.push_back(expectedResult(kinds[i], opA, imms[i]));
        end
        prog.push_back(rType(F_JR, 0, 0, 0, 5'd0));
    endtask

    // BNE loop sums n down to 1, JAL calls a routine at word 8 that adds k
    task automatic buildLoopProgram(input int n, input word_t k);
        prog = {iType(OP_ADDIU, 0, 8, n[15:0]),
                iType(OP_ADDIU, 0, `REG_V0, 16'h0),
                rType(F_ADDU, `REG_V0, 8, `REG_V0, 5'd0),
                iType(OP_ADDIU, 8, 8, 16'hFFFF),
                iType(OP_BNE, 8, 0, 16'hFFFD),
                jType(OP_JAL, `RESET_VECTOR + 32'h20),
                iType(OP_SW, 0, `REG_V0, 16'h1200),
                rType(F_JR, 0, 0, 0, 5'd0),
                iType(OP_ADDIU, `REG_V0, `REG_V0, k[15:0]),
                rType(F_JR, `REG_RA, 0, 0, 5'd0)};
        dataAddr.delete();
        dataVal.delete();
        expAddr.delete();
        expData.delete();
        expAddr.push_back(32'h1200);
        expData.push_back(expectedResult("sumcall", n, k));
    endtask

    initial begin
        #(TIMEOUT_NS);
        $display("Error: the CPU never halted within the time limit");
        abortRun();
    end

    // Bound assertions end the run as soon as one fails
    always @(negedge clk) begin
        if (dut0.assert0.failCount != 0) begin
            $display("Error: a bus protocol assertion failed");
            abortRun();
        end
    end

    initial begin
        int    loopN;
        word_t loopK;
        void'($urandom(55573));
        rstN    = 1'b0;
        stallEn = 1'b0;
        opA     = $urandom;
        opB     = $urandom;
        shamt   = 5'($urandom);
        imms[0] = 32'h8000 | ($urandom & 32'h7FFF);
        for (int i = 1; i < 5; i++) begin
            imms[i] = $urandom;
        end
        loopN = 1 + $urandom % 20;
        loopK = $urandom & 32'h7FFF;

        buildAluProgram();
        runProgram(1'b0);
        checkWrites(32'h0);
        rerunWithStalls(32'h0);

        buildImmProgram();
        runProgram(1'b0);
        checkWrites(expectedResult("lui", opA, imms[4]));

        buildLoopProgram(loopN, loopK);
        runProgram(1'b0);
        checkWrites(expectedResult("sumcall", loopN, loopK));
        rerunWithStalls(expectedResult("sumcall", loopN, loopK));

        if (dut0.assert0.failCount == 0) begin
            $display("Simulation finished: PASS");
            $finish;
        end else begin
            $display("Error: a bus protocol assertion failed");
            abortRun();
        end
    end

endmodule

`default_nettype wire

// File: sources.f
+incdir+hdl
hdl/mipsIsaPkg.sv
hdl/mipsCtrlPkg.sv
hdl/regFile.sv
hdl/aluUnit.sv
hdl/controlDecoder.sv
hdl/mipsCpuBus.sv
tb/busMemModel.sv
tb/mipsCpuBusAssert.sv
tb/mipsCpuBusTb.sv
